// File: conv_loop_defines.svh
`ifndef CONV_LOOP_DEFINES_SVH
`define CONV_LOOP_DEFINES_SVH

//////////////////////////////////////////////////
// Pixel stream
//////////////////////////////////////////////////

// Width of one pixel word
`define CL_DATA_WIDTH 16

//////////////////////////////////////////////////
// Input channel loop
//////////////////////////////////////////////////

// Input channel taps
`define CL_CH_IN 4

// Pixels taken from each tap per segment
`define CL_WIN 3

// Spacing between neighbouring input taps
`define CL_GAP 5

// Slots spent on one tap before moving on
`define CL_SEG_LEN (`CL_WIN + `CL_GAP)

//////////////////////////////////////////////////
// Output channel replay
//////////////////////////////////////////////////

// Copies of the gathered block
`define CL_CH_OUT 3

// One replay stage, never shorter than a gathered block
`define CL_REPLAY_DEPTH (`CL_CH_IN * `CL_SEG_LEN)

`endif

// File: conv_loop_pkg.sv
`include "conv_loop_defines.svh"

package conv_loop_pkg;

	//////////////////////////////////////////////////
	// Stream beat
	//////////////////////////////////////////////////

	// One pixel plus its qualifier
	// Data only counts in a cycle where valid is high
	typedef struct packed {
		logic                      valid;
		logic [`CL_DATA_WIDTH-1:0] data;
	} pixel_beat_t;

	//////////////////////////////////////////////////
	// Gather phase
	//////////////////////////////////////////////////

	// Where the current slot sits inside a segment
	// EMIT for the first CL_WIN slots, SKIP for the gap after them
	typedef enum logic {
		GATHER_EMIT = 1'b0,
		GATHER_SKIP = 1'b1
	} gather_phase_e;

endpackage

// File: pixel_delay_line.sv
`include "conv_loop_defines.svh"

module pixel_delay_line #(
	parameter int DEPTH = 1
) (
	input  logic                      clk,
	input  logic                      reset,
	input  conv_loop_pkg::pixel_beat_t beat_in,
	output conv_loop_pkg::pixel_beat_t beat_out
);

	// Qualifier and payload chains
	logic [DEPTH-1:0]          valid_sr;
	logic [`CL_DATA_WIDTH-1:0] data_sr [DEPTH];

	//////////////////////////////////////////////////
	// Valid chain
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_sr <= '0;
		end else begin
			valid_sr[0] <= beat_in.valid;
			for (int i = 1; i < DEPTH; i++) begin
				valid_sr[i] <= valid_sr[i-1];
			end
		end
	end

	//////////////////////////////////////////////////
	// Data chain
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		data_sr[0] <= beat_in.data;
		for (int i = 1; i < DEPTH; i++) begin
			data_sr[i] <= data_sr[i-1];
		end
	end

	// Last stage is DEPTH cycles behind the input
	assign beat_out.valid = valid_sr[DEPTH-1];
	assign beat_out.data  = data_sr[DEPTH-1];

endmodule

// File: channel_loop_gather.sv
`include "conv_loop_defines.svh"

module channel_loop_gather (
	input  logic                      clk,
	input  logic                      reset,
	input  conv_loop_pkg::pixel_beat_t pixel_in,
	output conv_loop_pkg::pixel_beat_t gathered
);

	localparam int CH_W   = $clog2(`CL_CH_IN);
	localparam int SLOT_W = $clog2(`CL_SEG_LEN);

	localparam logic [CH_W-1:0]   LAST_CH   = CH_W'(`CL_CH_IN - 1);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`CL_SEG_LEN - 1);
	localparam logic [SLOT_W-1:0] WIN_END   = SLOT_W'(`CL_WIN);

	conv_loop_pkg::pixel_beat_t tap [`CL_CH_IN];
	conv_loop_pkg::pixel_beat_t sel_beat;

	logic [CH_W-1:0]   ch_cnt;
	logic [SLOT_W-1:0] slot_cnt;
	logic              block_done;

	// Beat captured in the previous slot and the phase of that slot
	logic                          slot_valid;
	logic [`CL_DATA_WIDTH-1:0]     slot_data;
	conv_loop_pkg::gather_phase_e  phase;
	logic                          emit;

	//////////////////////////////////////////////////
	// Staggered channel taps
	//////////////////////////////////////////////////

	// Taps sit CL_GAP apart while the walk spends CL_SEG_LEN slots on each,
	// so slot c of channel k lands on pixel k*CL_WIN + c of the burst
	assign tap[0] = pixel_in;

	for (genvar k = 0; k < `CL_CH_IN - 1; k++) begin : g_tap
		pixel_delay_line #(
			.DEPTH(`CL_GAP)
		) tap_dl_i (
			.clk     (clk),
			.reset   (reset),
			.beat_in (tap[k]),
			.beat_out(tap[k+1])
		);
	end

	assign sel_beat = tap[ch_cnt];

	//////////////////////////////////////////////////
	// Channel and slot walk
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt     <= '0;
			slot_cnt   <= '0;
			block_done <= 1'b0;
			slot_valid <= 1'b0;
			phase      <= conv_loop_pkg::GATHER_EMIT;
		end else if (block_done) begin
			// Whole block taken, wait for the burst to drain off tap 0
			slot_valid <= 1'b0;
			phase      <= conv_loop_pkg::GATHER_SKIP;
			if (!sel_beat.valid) begin
				block_done <= 1'b0;
				phase      <= conv_loop_pkg::GATHER_EMIT;
			end
		end else if (sel_beat.valid) begin
			slot_valid <= 1'b1;
			if (slot_cnt < WIN_END) begin
				phase <= conv_loop_pkg::GATHER_EMIT;
			end else begin
				phase <= conv_loop_pkg::GATHER_SKIP;
			end

			if (slot_cnt == LAST_SLOT) begin
				slot_cnt <= '0;
				if (ch_cnt == LAST_CH) begin
					ch_cnt     <= '0;
					block_done <= 1'b1;
				end else begin
					ch_cnt <= ch_cnt + 1'b1;
				end
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end
		end else begin
			// Hole in the selected tap ends the block early
			ch_cnt     <= '0;
			slot_cnt   <= '0;
			slot_valid <= 1'b0;
			phase      <= conv_loop_pkg::GATHER_EMIT;
		end
	end

	// Payload follows the selected tap every slot
	always_ff @(posedge clk) begin
		slot_data <= sel_beat.data;
	end

	//////////////////////////////////////////////////
	// Output beat
	//////////////////////////////////////////////////

	// Gap slots are captured but never leave the block
	assign emit = slot_valid && (phase == conv_loop_pkg::GATHER_EMIT);

	assign gathered.valid = emit;
	assign gathered.data  = emit ? slot_data : '0;

endmodule

// File: channel_out_replay.sv
`include "conv_loop_defines.svh"

module channel_out_replay (
	input  logic                              clk,
	input  logic                              reset,
	input  conv_loop_pkg::pixel_beat_t         gathered,
	output conv_loop_pkg::pixel_beat_t         pixel_out,
	output logic [$clog2(`CL_CH_OUT)-1:0]     out_channel
);

	localparam int OUT_W = $clog2(`CL_CH_OUT);

	// Stage j holds the gathered stream j replay depths back
	conv_loop_pkg::pixel_beat_t stage [`CL_CH_OUT];

	logic [OUT_W-1:0] sel_idx;
	logic             any_valid;

	//////////////////////////////////////////////////
	// Output channel chain
	//////////////////////////////////////////////////

	assign stage[0] = gathered;

	for (genvar j = 0; j < `CL_CH_OUT - 1; j++) begin : g_stage
		pixel_delay_line #(
			.DEPTH(`CL_REPLAY_DEPTH)
		) stage_dl_i (
			.clk     (clk),
			.reset   (reset),
			.beat_in (stage[j]),
			.beat_out(stage[j+1])
		);
	end

	//////////////////////////////////////////////////
	// Deepest valid stage
	//////////////////////////////////////////////////

	// Later stages overwrite earlier ones, so the deepest valid wins
	always_comb begin
		sel_idx   = '0;
		any_valid = 1'b0;
		for (int j = 0; j < `CL_CH_OUT; j++) begin
			if (stage[j].valid) begin
				sel_idx   = OUT_W'(j);
				any_valid = 1'b1;
			end
		end
	end

	// Idle output is all zero, index included
	always_comb begin
		if (any_valid) begin
			pixel_out   = stage[sel_idx];
			out_channel = sel_idx;
		end else begin
			pixel_out   = '0;
			out_channel = '0;
		end
	end

endmodule

// File: conv_loop_top.sv
`include "conv_loop_defines.svh"

module conv_loop_top (
	input  logic                              clk,
	input  logic                              reset,
	input  conv_loop_pkg::pixel_beat_t         pixel_in,
	output conv_loop_pkg::pixel_beat_t         pixel_out,
	output logic [$clog2(`CL_CH_OUT)-1:0]     out_channel
);

	// Channel-ordered block between the two loops
	conv_loop_pkg::pixel_beat_t gathered;

	//////////////////////////////////////////////////
	// Input channel loop
	//////////////////////////////////////////////////

	channel_loop_gather gather_i (
		.clk     (clk),
		.reset   (reset),
		.pixel_in(pixel_in),
		.gathered(gathered)
	);

	//////////////////////////////////////////////////
	// Output channel replay
	//////////////////////////////////////////////////

	channel_out_replay replay_i (
		.clk        (clk),
		.reset      (reset),
		.gathered   (gathered),
		.pixel_out  (pixel_out),
		.out_channel(out_channel)
	);

endmodule

// File: conv_loop_sva.sv
`include "conv_loop_defines.svh"

module conv_loop_sva (
	input logic                          clk,
	input logic                          reset,
	input conv_loop_pkg::pixel_beat_t    gathered,
	input conv_loop_pkg::gather_phase_e  phase,
	input conv_loop_pkg::pixel_beat_t    pixel_out,
	input logic [$clog2(`CL_CH_OUT)-1:0] out_channel
);

	timeunit 1ns;
	timeprecision 1ps;

	// Idle beats carry no payload
	idle_data_zero: assert property (@(posedge clk) disable iff (reset)
		!pixel_out.valid |-> pixel_out.data == '0)
		else $error("pixel_out.data not zero while valid is low");

	channel_in_range: assert property (@(posedge clk) disable iff (reset)
		int'(out_channel) < `CL_CH_OUT)
		else $error("out_channel beyond the last output copy");

	// Never more than CL_WIN beats before the gap slots
	window_then_gap: assert property (@(posedge clk) disable iff (reset)
		gathered.valid [*`CL_WIN] |=> !gathered.valid)
		else $error("gathered.valid high past the end of a window");

	// SKIP starts right after a full window of CL_WIN beats
	phase_at_window_end: assert property (@(posedge clk) disable iff (reset)
		$rose(phase == conv_loop_pkg::GATHER_SKIP) |->
			$past(gathered.valid) && $past(gathered.valid, `CL_WIN) &&
			!$past(gathered.valid, `CL_WIN + 1))
		else $error("gather phase entered SKIP away from the end of a window");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !pixel_out.valid)
		else $error("pixel_out.valid high right after reset");

endmodule

bind conv_loop_top conv_loop_sva sva_i (
	.clk        (clk),
	.reset      (reset),
	.gathered   (gathered),
	.phase      (gather_i.phase),
	.pixel_out  (pixel_out),
	.out_channel(out_channel)
);

// File: conv_loop_tb.sv
`include "conv_loop_defines.svh"

module conv_loop_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_N      = 64;
	localparam int WAIT_LIMIT = 400;
	localparam int IDLE_GAP   = 40;

	logic                          clk;
	logic                          reset;
	conv_loop_pkg::pixel_beat_t    pixel_in;
	conv_loop_pkg::pixel_beat_t    pixel_out;
	logic [$clog2(`CL_CH_OUT)-1:0] out_channel;

	integer                    seed;
	int                        error_count;
	int                        case_count;
	int                        cycle = 0;
	logic                      stalled;
	logic [`CL_DATA_WIDTH-1:0] x [MAX_N];

	// Valid output beats in arrival order
	logic [`CL_DATA_WIDTH-1:0] got_data [$];
	int                        got_chan [$];
	int                        got_cycle [$];

	conv_loop_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.pixel_in   (pixel_in),
		.pixel_out  (pixel_out),
		.out_channel(out_channel)
	);

	always #50 clk = ~clk;

	// Collect valid output beats at the falling edge
	always @(negedge clk) begin
		if (!reset && pixel_out.valid) begin
			got_data.push_back(pixel_out.data);
			got_chan.push_back(int'(out_channel));
			got_cycle.push_back(cycle);
		end
		cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("FAILED at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic check_idle(input string phase_desc);
		@(negedge clk);
		if (pixel_out.valid !== 1'b0) begin
			$display("FAILED at time %0t: pixel_out.valid expected 0, got %b %s",
				$time, pixel_out.valid, phase_desc);
			error_count++;
		end
	endtask

	// Block k is reached only once block k-1 has run all of its slots
	function automatic int expected_count(input int n);
		int   cnt;
		logic reached;
		cnt     = 0;
		reached = 1'b1;
		for (int k = 0; k < `CL_CH_IN; k++) begin
			if (reached) begin
				for (int c = 0; c < `CL_WIN; c++) begin
					if (k * `CL_WIN + c < n) begin
						cnt++;
					end
				end
			end
			if (k * `CL_WIN + `CL_SEG_LEN - 1 >= n) begin
				reached = 1'b0;
			end
		end
		return cnt;
	endfunction

	//////////////////////////////////////////////////
	// One burst
	//////////////////////////////////////////////////

	task automatic run_case(input int n, input int m);
		int drive_cycle;
		int waited;
		int j;
		int i;
		int k;
		int c;
		int exp_cycle;

		if (m != expected_count(n)) begin
			$display("Case file expects %0d gathered beats for burst %0d, rule gives %0d",
				m, n, expected_count(n));
			error_count++;
		end
		check_idle("between cases");
		got_data.delete();
		got_chan.delete();
		got_cycle.delete();
		for (int p = 0; p < n; p++) begin
			x[p] = `CL_DATA_WIDTH'($random(seed));
		end

		drive_cycle = 0;
		for (int p = 0; p < n; p++) begin
			@(posedge clk);
			if (p == 0) begin
				drive_cycle = cycle;
			end
			pixel_in.valid <= 1'b1;
			pixel_in.data  <= x[p];
		end
		@(posedge clk);
		pixel_in <= '0;

		waited = 0;
		while (got_data.size() < `CL_CH_OUT * m && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (got_data.size() < `CL_CH_OUT * m) begin
			$display("Timeout: burst of %0d pixels stalled with %0d of %0d output beats",
				n, got_data.size(), `CL_CH_OUT * m);
			error_count++;
			stalled = 1'b1;
		end else begin
			// The replay chain must stay empty through the quiet window
			for (int w = 0; w < IDLE_GAP; w++) begin
				@(posedge clk);
			end
			if (got_data.size() != `CL_CH_OUT * m) begin
				report_mismatch("output beat count", `CL_CH_OUT * m, got_data.size());
			end
			for (int p = 0; p < `CL_CH_OUT * m && p < got_data.size(); p++) begin
				j = p / m;
				i = p % m;
				k = i / `CL_WIN;
				c = i % `CL_WIN;
				// One cycle of latency plus the slot walk and the copy offset
				exp_cycle = drive_cycle + 1 + k * `CL_SEG_LEN + c + j * `CL_REPLAY_DEPTH;
				if (got_chan[p] != j) begin
					report_mismatch("out_channel", j, got_chan[p]);
				end
				if (got_data[p] !== x[k * `CL_WIN + c]) begin
					report_mismatch("pixel_out.data", int'(x[k * `CL_WIN + c]), int'(got_data[p]));
				end
				if (got_cycle[p] != exp_cycle) begin
					report_mismatch("pixel_out.valid cycle", exp_cycle, got_cycle[p]);
				end
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int    fd;
		int    status;
		int    n;
		int    m;
		string line;

		clk         = 1'b0;
		reset       = 1'b1;
		pixel_in    = '0;
		seed        = 32'ha431_37f9;
		error_count = 0;
		case_count  = 0;
		stalled     = 1'b0;

		for (int r = 0; r < 16; r++) begin
			check_idle("during reset");
		end
		@(posedge clk);
		reset <= 1'b0;

		fd = $fopen("conv_loop_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open conv_loop_cases.txt");
			error_count++;
		end else begin
			while (!$feof(fd) && !stalled) begin
				line   = "";
				status = $fgets(line, fd);
				if (status != 0 && $sscanf(line, "%d %d", n, m) == 2) begin
					if (n < 1 || n > MAX_N) begin
						$display("Burst length %0d is outside 1 to %0d", n, MAX_N);
						error_count++;
					end else begin
						run_case(n, m);
						case_count++;
					end
				end
			end
			$fclose(fd);
		end
		if (case_count == 0) begin
			$display("No case was read from conv_loop_cases.txt");
			error_count++;
		end

		$display("Cases run: %0d, errors: %0d", case_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: conv_loop_cases.txt
# Columns: burst length N, expected gathered beat count M
# Each block of the gather walk yields CL_WIN beats while the burst lasts
32 12
40 12
17 12
16 12
12 9
10 6
2 2

// File: compile.f
+incdir+.
conv_loop_pkg.sv
pixel_delay_line.sv
channel_loop_gather.sv
channel_out_replay.sv
conv_loop_top.sv
conv_loop_sva.sv
conv_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the conv loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module conv_loop_tb -f compile.f -o conv_loop_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/conv_loop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation passed"
exit 0
